// File: rtl/jag_mem_pkg.sv
package jag_mem_pkg;

	////////////////////
	// Bank geometry

	localparam int row_bits       = 10;
	localparam int col_bits       = 8;
	localparam int word_addr_bits = row_bits + col_bits;
	localparam int cpu_addr_bits  = 24;
	localparam int data_bits      = 16;

	////////////////////
	// Interrupt vector remap

	// CPU space cycle
	localparam logic [2:0] fc_int_ack = 3'b111;

	// Level-2 autovector at bytes 0x68 to 0x6B
	localparam logic [cpu_addr_bits-1:0] autovec_base = 24'h000068;

	// User interrupt 0 vector
	localparam logic [cpu_addr_bits-1:0] user_vec_base = 24'h000100;

	////////////////////
	// DRAM word address

	typedef struct packed {
		logic [col_bits-1:0] col;
		logic [row_bits-1:0] row;
	} dram_rc_t;

	// Flat word index or the same bits split into column and row
	typedef union packed {
		logic [word_addr_bits-1:0] flat;
		dram_rc_t                  rc;
	} dram_addr_u;

endpackage

// File: rtl/jag_mem_ifs.sv
`timescale 1ns/1ps

// Request channel from the bus adapter to the DRAM sequencer
interface mem_req_if;

	import jag_mem_pkg::*;

	logic                 start;
	logic                 write;
	logic [1:0]           byte_ena;
	dram_addr_u           addr;
	logic [data_bits-1:0] wdata;
	logic                 ack;
	logic [data_bits-1:0] rdata;

	modport requester
	(
		output start, write, byte_ena, addr, wdata,
		input  ack, rdata
	);

	modport responder
	(
		input  start, write, byte_ena, addr, wdata,
		output ack, rdata
	);

endinterface

// Multiplexed-address DRAM pins
interface dram_if;

	import jag_mem_pkg::*;

	logic [row_bits-1:0]  ma;
	logic                 ras_n;
	logic                 cas_n;
	logic                 uw_n;
	logic                 lw_n;
	logic                 oe_n;
	logic [data_bits-1:0] d;
	logic [data_bits-1:0] q;

	modport controller
	(
		output ma, ras_n, cas_n, uw_n, lw_n, oe_n, d,
		input  q
	);

	modport bank
	(
		input  ma, ras_n, cas_n, uw_n, lw_n, oe_n, d,
		output q
	);

endinterface

// File: rtl/cpu_bus_adapter.sv
`timescale 1ns/1ps

module cpu_bus_adapter
(
	input  logic                                  sys_clk,
	input  logic                                  rst_n,
	input  logic                                  cpu_rd_ena,
	input  logic                                  cpu_wr_ena,
	input  logic [1:0]                            cpu_byte_ena,
	input  logic [jag_mem_pkg::cpu_addr_bits-1:0] cpu_address,
	input  logic [jag_mem_pkg::data_bits-1:0]     cpu_wr_data,
	input  logic [2:0]                            cpu_fc,
	input  logic                                  int_n,
	output logic [jag_mem_pkg::data_bits-1:0]     cpu_rd_data,
	output logic                                  cpu_data_ack,
	mem_req_if.requester                          req
);

	import jag_mem_pkg::*;

	logic                     busy;
	logic                     new_req;
	logic                     vec_hit;
	logic [cpu_addr_bits-1:0] eff_address;

	// Held enable counts once per access
	assign new_req = !busy && (cpu_rd_ena || cpu_wr_ena);

	////////////////////
	// Autovector remap

	// Level-2 autovector fetched while the interrupt line is active
	assign vec_hit = (cpu_fc == fc_int_ack) && !int_n &&
		(cpu_address[cpu_addr_bits-1:2] == autovec_base[cpu_addr_bits-1:2]);

	assign eff_address = vec_hit ?
		{user_vec_base[cpu_addr_bits-1:2], cpu_address[1:0]} : cpu_address;

	////////////////////
	// Request issue

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			req.start <= 1'b0;
		end
		else
		begin
			req.start <= new_req;
			// Busy until the sequencer acknowledges
			if (req.ack)
				busy <= 1'b0;
			else if (new_req)
				busy <= 1'b1;
		end
	end

	// Request fields stay put for the whole access
	always_ff @(posedge sys_clk)
	begin
		if (new_req)
		begin
			req.write     <= cpu_wr_ena;
			req.byte_ena  <= cpu_byte_ena;
			req.addr.flat <= eff_address[word_addr_bits:1];
			req.wdata     <= cpu_wr_data;
		end
	end

	assign cpu_data_ack = req.ack;
	assign cpu_rd_data  = req.rdata;

endmodule

// File: rtl/dram_controller.sv
`timescale 1ns/1ps

module dram_controller
(
	input  logic         sys_clk,
	input  logic         rst_n,
	mem_req_if.responder req,
	dram_if.controller   dram
);

	import jag_mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_row,
		st_col,
		st_done
	} state_t;

	state_t state;
	logic   pre;
	logic   ras_act;
	logic   col_act;

	////////////////////
	// Sequencer

	always_ff @(posedge sys_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= st_idle;
			pre   <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (req.start)
						state <= st_row;
				end
				st_row:
				begin
					state <= st_col;
				end
				st_col:
				begin
					state <= st_done;
				end
				default:
				begin
					// Ack cycle first, then precharge
					pre <= !pre;
					if (pre)
						state <= st_idle;
				end
			endcase
		end
	end

	assign ras_act = (state == st_row) || (state == st_col);
	assign col_act = (state == st_col);

	assign req.ack = (state == st_done) && !pre;

	////////////////////
	// DRAM pins

	assign dram.ras_n = !ras_act;
	assign dram.cas_n = !col_act;
	assign dram.oe_n  = !(col_act && !req.write);

	// Early write with WE low from the RAS cycle on
	assign dram.uw_n = !(ras_act && req.write && req.byte_ena[1]);
	assign dram.lw_n = !(ras_act && req.write && req.byte_ena[0]);
	assign dram.d    = req.wdata;

	// Address mux flips mid-cycle so ma is settled at each strobe edge
	always_ff @(negedge sys_clk)
	begin
		if (ras_act)
			dram.ma <= {{(row_bits - col_bits){1'b0}}, req.addr.rc.col};
		else
			dram.ma <= req.addr.rc.row;
	end

	// Read word sampled as CAS ends
	always_ff @(posedge sys_clk)
	begin
		if (col_act && !req.write)
			req.rdata <= dram.q;
	end

endmodule

// File: rtl/dram_bank.sv
`timescale 1ns/1ps

module dram_bank
(
	dram_if.bank dram
);

	import jag_mem_pkg::*;

	localparam int half = data_bits / 2;

	logic [data_bits-1:0] mem [0:(1 << word_addr_bits)-1];
	logic [row_bits-1:0]  row_q;
	logic [col_bits-1:0]  col_q;
	dram_addr_u           rd_addr;
	dram_addr_u           wr_addr;

	initial
	begin
		for (int i = 0; i < (1 << word_addr_bits); i++)
			mem[i] = '0;
	end

	// Word index from the latched row and column
	always_comb
	begin
		rd_addr.rc.col = col_q;
		rd_addr.rc.row = row_q;
		wr_addr.rc.col = dram.ma[col_bits-1:0];
		wr_addr.rc.row = row_q;
	end

	always @(negedge dram.ras_n)
	begin
		row_q <= dram.ma;
	end

	// Column strobe latches the column and writes bytes while OE is off
	always @(negedge dram.cas_n)
	begin
		col_q <= dram.ma[col_bits-1:0];
		if (!dram.uw_n && dram.oe_n)
			mem[wr_addr.flat][data_bits-1:half] <= dram.d[data_bits-1:half];
		if (!dram.lw_n && dram.oe_n)
			mem[wr_addr.flat][half-1:0] <= dram.d[half-1:0];
	end

	assign dram.q = mem[rd_addr.flat];

endmodule

// File: rtl/jag_mem_top.sv
`timescale 1ns/1ps

module jag_mem_top
(
	input  logic                                  sys_clk,
	input  logic                                  rst_n,
	input  logic                                  cpu_rd_ena,
	input  logic                                  cpu_wr_ena,
	input  logic [1:0]                            cpu_byte_ena,
	input  logic [jag_mem_pkg::cpu_addr_bits-1:0] cpu_address,
	input  logic [jag_mem_pkg::data_bits-1:0]     cpu_wr_data,
	input  logic [2:0]                            cpu_fc,
	input  logic                                  int_n,
	output logic [jag_mem_pkg::data_bits-1:0]     cpu_rd_data,
	output logic                                  cpu_data_ack
);

	mem_req_if req_if ();
	dram_if    dram_bus ();

	////////////////////
	// CPU side

	cpu_bus_adapter adapter_i
	(
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.cpu_rd_ena   (cpu_rd_ena),
		.cpu_wr_ena   (cpu_wr_ena),
		.cpu_byte_ena (cpu_byte_ena),
		.cpu_address  (cpu_address),
		.cpu_wr_data  (cpu_wr_data),
		.cpu_fc       (cpu_fc),
		.int_n        (int_n),
		.cpu_rd_data  (cpu_rd_data),
		.cpu_data_ack (cpu_data_ack),
		.req          (req_if.requester)
	);

	////////////////////
	// Memory side

	dram_controller ctrl_i
	(
		.sys_clk (sys_clk),
		.rst_n   (rst_n),
		.req     (req_if.responder),
		.dram    (dram_bus.controller)
	);

	// Single 16-bit bank
	dram_bank bank_i
	(
		.dram (dram_bus.bank)
	);

endmodule

// File: bench/jag_mem_assertions.sv
`timescale 1ns/1ps

module jag_mem_assertions
(
	input logic sys_clk,
	input logic rst_n,
	input logic ras_n,
	input logic cas_n,
	input logic uw_n,
	input logic lw_n,
	input logic oe_n,
	input logic cpu_data_ack
);

	int failures = 0;

	////////////////////
	// DRAM strobes

	// Column strobe one cycle behind the row strobe
	cas_after_ras: assert property (@(posedge sys_clk) disable iff (!rst_n)
		$fell(cas_n) |-> (!$past(ras_n) && $past(ras_n, 2)))
	else
	begin
		$error("cas_n fell without ras_n falling one cycle earlier");
		failures++;
	end

	we_inside_ras: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(!uw_n || !lw_n) |-> !ras_n)
	else
	begin
		$error("write strobe low while ras_n is high");
		failures++;
	end

	// Everything idle right out of reset
	idle_after_reset: assert property (@(posedge sys_clk)
		$rose(rst_n) |-> (ras_n && cas_n && oe_n && uw_n && lw_n))
	else
	begin
		$error("DRAM strobes not idle in the first cycle after reset");
		failures++;
	end

	////////////////////
	// CPU side

	ack_single_cycle: assert property (@(posedge sys_clk) disable iff (!rst_n)
		cpu_data_ack |=> !cpu_data_ack)
	else
	begin
		$error("cpu_data_ack high for two cycles in a row");
		failures++;
	end

endmodule

bind jag_mem_top jag_mem_assertions assertions_i
(
	.sys_clk      (sys_clk),
	.rst_n        (rst_n),
	.ras_n        (dram_bus.ras_n),
	.cas_n        (dram_bus.cas_n),
	.uw_n         (dram_bus.uw_n),
	.lw_n         (dram_bus.lw_n),
	.oe_n         (dram_bus.oe_n),
	.cpu_data_ack (cpu_data_ack)
);

// File: bench/tb_jag_mem.sv
`timescale 1ns/1ps

module tb_jag_mem;

	import jag_mem_pkg::*;

	localparam int         ack_timeout = 20;
	localparam int         ack_latency = 4;
	localparam logic [2:0] fc_data     = 3'b101;

	logic                     sys_clk;
	logic                     rst_n;
	logic                     cpu_rd_ena;
	logic                     cpu_wr_ena;
	logic [1:0]               cpu_byte_ena;
	logic [cpu_addr_bits-1:0] cpu_address;
	logic [data_bits-1:0]     cpu_wr_data;
	logic [2:0]               cpu_fc;
	logic                     int_n;
	logic [data_bits-1:0]     cpu_rd_data;
	logic                     cpu_data_ack;

	logic [15:0] lfsr_state;
	int          error_count;
	int          test_count;
	int          total_errors;
	string       current_test;

	jag_mem_top dut_i (.*);

	initial
	begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	////////////////////
	// Helpers

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] cur);
		return {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
	endfunction

	task automatic random_word(output logic [data_bits-1:0] word);
		word = '0;
		for (int i = 0; i < data_bits; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			word = {word[data_bits-2:0], lfsr_state[15]};
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input int errors_before);
		test_count++;
		$display("%s finished with %0d errors", current_test, error_count - errors_before);
	endtask

	// One bus cycle with the enable held until the data acknowledge
	task automatic bus_access(input logic write, input logic [1:0] byte_ena,
		input logic [cpu_addr_bits-1:0] address, input logic [data_bits-1:0] wdata,
		input logic [2:0] fc, input logic int_line,
		output logic [data_bits-1:0] rdata, output int cycles);
		logic acked;
		acked  = 1'b0;
		cycles = 0;
		@(posedge sys_clk);
		cpu_rd_ena   <= !write;
		cpu_wr_ena   <= write;
		cpu_byte_ena <= byte_ena;
		cpu_address  <= address;
		cpu_wr_data  <= wdata;
		cpu_fc       <= fc;
		int_n        <= int_line;
		while (!acked && cycles < ack_timeout)
		begin
			@(negedge sys_clk);
			cycles++;
			acked = cpu_data_ack;
		end
		rdata = cpu_rd_data;
		if (!acked)
		begin
			$display("%s: no data acknowledge within %0d cycles at address %h",
				current_test, ack_timeout, address);
			error_count++;
		end
		@(posedge sys_clk);
		cpu_rd_ena <= 1'b0;
		cpu_wr_ena <= 1'b0;
		int_n      <= 1'b1;
	endtask

	task automatic cpu_write(input logic [cpu_addr_bits-1:0] address,
		input logic [data_bits-1:0] data, input logic [1:0] byte_ena);
		logic [data_bits-1:0] unused;
		int                   cycles;
		bus_access(1'b1, byte_ena, address, data, fc_data, 1'b1, unused, cycles);
	endtask

	task automatic cpu_read(input logic [cpu_addr_bits-1:0] address, input logic [2:0] fc,
		input logic int_line, output logic [data_bits-1:0] data);
		int cycles;
		bus_access(1'b0, 2'b11, address, '0, fc, int_line, data, cycles);
	endtask

	////////////////////
	// Directed tests

	task automatic ack_timing();
		logic [data_bits-1:0] word;
		logic [data_bits-1:0] rdata;
		int                   cycles;
		int                   errors_before;
		current_test  = "ack_timing";
		errors_before = error_count;
		// Still no acknowledge before the first request
		repeat (3)
		begin
			@(negedge sys_clk);
			check_value(current_test, 16'h0000, {15'b0, cpu_data_ack});
		end
		random_word(word);
		// Counted from the driving edge so the count is one past the latency
		bus_access(1'b1, 2'b11, 24'h000400, word, fc_data, 1'b1, rdata, cycles);
		check_value(current_test, 16'(ack_latency + 1), 16'(cycles));
		bus_access(1'b0, 2'b11, 24'h000400, '0, fc_data, 1'b1, rdata, cycles);
		check_value(current_test, 16'(ack_latency + 1), 16'(cycles));
		check_value(current_test, word, rdata);
		report_test(errors_before);
	endtask

	// 0x202 differs from 0x200 only in the row and 0xa00 and 0x40200 only in the column
	task automatic read_after_write();
		logic [cpu_addr_bits-1:0] addrs [6];
		logic [data_bits-1:0]     words [6];
		logic [data_bits-1:0]     rdata;
		int                       errors_before;
		current_test  = "read_after_write";
		errors_before = error_count;
		addrs = '{24'h000200, 24'h000202, 24'h000a00, 24'h040200, 24'h07fffe, 24'h000000};
		for (int i = 0; i < 6; i++)
		begin
			random_word(words[i]);
			cpu_write(addrs[i], words[i], 2'b11);
		end
		for (int i = 0; i < 6; i++)
		begin
			cpu_read(addrs[i], fc_data, 1'b1, rdata);
			check_value(current_test, words[i], rdata);
		end
		report_test(errors_before);
	endtask

	task automatic byte_lanes();
		logic [data_bits-1:0] full;
		logic [data_bits-1:0] part;
		logic [data_bits-1:0] expected;
		logic [data_bits-1:0] rdata;
		int                   errors_before;
		current_test  = "byte_lanes";
		errors_before = error_count;
		random_word(full);
		random_word(part);
		cpu_write(24'h001000, full, 2'b11);
		// Lower byte only
		cpu_write(24'h001000, part, 2'b01);
		expected = {full[15:8], part[7:0]};
		cpu_read(24'h001000, fc_data, 1'b1, rdata);
		check_value(current_test, expected, rdata);
		// then the upper byte only
		random_word(part);
		cpu_write(24'h001000, part, 2'b10);
		expected = {part[15:8], expected[7:0]};
		cpu_read(24'h001000, fc_data, 1'b1, rdata);
		check_value(current_test, expected, rdata);
		report_test(errors_before);
	endtask

	task automatic aliasing();
		logic [data_bits-1:0] word;
		logic [data_bits-1:0] rdata;
		int                   errors_before;
		current_test  = "aliasing";
		errors_before = error_count;
		random_word(word);
		cpu_write(24'h001234, word, 2'b11);
		cpu_read(24'h081234, fc_data, 1'b1, rdata);
		check_value(current_test, word, rdata);
		// Upper address bits ignored as well
		random_word(word);
		cpu_write(24'hf81236, word, 2'b11);
		cpu_read(24'h001236, fc_data, 1'b1, rdata);
		check_value(current_test, word, rdata);
		report_test(errors_before);
	endtask

	task automatic vector_remap();
		logic [data_bits-1:0] user_word;
		logic [data_bits-1:0] next_word;
		logic [data_bits-1:0] vec_word;
		logic [data_bits-1:0] rdata;
		int                   errors_before;
		current_test  = "vector_remap";
		errors_before = error_count;
		random_word(user_word);
		random_word(next_word);
		random_word(vec_word);
		cpu_write(24'h000100, user_word, 2'b11);
		cpu_write(24'h000102, next_word, 2'b11);
		cpu_write(24'h000068, vec_word, 2'b11);
		cpu_read(24'h000068, 3'b111, 1'b0, rdata);
		check_value(current_test, user_word, rdata);
		cpu_read(24'h00006a, 3'b111, 1'b0, rdata);
		check_value(current_test, next_word, rdata);
		// No remap without the interrupt or outside interrupt acknowledge
		cpu_read(24'h000068, 3'b111, 1'b1, rdata);
		check_value(current_test, vec_word, rdata);
		cpu_read(24'h000068, 3'b101, 1'b0, rdata);
		check_value(current_test, vec_word, rdata);
		report_test(errors_before);
	endtask

	////////////////////
	// Main sequence

	initial
	begin
		lfsr_state   = 16'd48;
		error_count  = 0;
		test_count   = 0;
		current_test = "reset";
		rst_n        = 1'b0;
		cpu_rd_ena   = 1'b0;
		cpu_wr_ena   = 1'b0;
		cpu_byte_ena = 2'b00;
		cpu_address  = '0;
		cpu_wr_data  = '0;
		cpu_fc       = fc_data;
		int_n        = 1'b1;
		repeat (2)
		begin
			@(posedge sys_clk);
			@(negedge sys_clk);
			check_value(current_test, 16'h0000, {15'b0, cpu_data_ack});
		end
		@(posedge sys_clk);
		rst_n <= 1'b1;

		ack_timing();
		read_after_write();
		byte_lanes();
		aliasing();
		vector_remap();

		total_errors = error_count + dut_i.assertions_i.failures;
		$display("%0d tests, %0d check errors, %0d assertion failures",
			test_count, error_count, dut_i.assertions_i.failures);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: flist.f
rtl/jag_mem_pkg.sv
rtl/jag_mem_ifs.sv
rtl/cpu_bus_adapter.sv
rtl/dram_controller.sv
rtl/dram_bank.sv
rtl/jag_mem_top.sv
bench/jag_mem_assertions.sv
bench/tb_jag_mem.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_jag_mem -f flist.f -o tb_jag_mem || exit 1
sim_out="$(./obj_dir/tb_jag_mem +verilator+error+limit+100)"
echo "$sim_out"
echo "$sim_out" | grep -q "TESTBENCH PASSED" && echo "run.sh: pass" || { echo "run.sh: fail"; exit 1; }
